//--- common/u1e_pkg.sv
// Radio control core shared definitions
// Wishbone and settings bus widths, register maps,
// bus structs and the 32-bit word seen as whole or as halves

`default_nettype none

package u1e_pkg;

   //////////////////////////////
   // Bus widths
   localparam int WB_DW  = 16;   // Wishbone data
   localparam int WB_AW  = 11;   // Wishbone address
   localparam int WB_SW  = 2;    // Byte selects
   localparam int SET_AW = 8;    // Settings address
   localparam int SET_DW = 32;   // Settings data

   //////////////////////////////
   // Settings register map
   localparam logic [SET_AW-1:0] SR_TIME64       = 8'd42;   // +0 seconds, +1 ticks
   localparam logic [SET_AW-1:0] SR_REG_TEST32   = 8'd60;
   localparam logic [SET_AW-1:0] SR_GLOBAL_RESET = 8'd63;

   // Misc slave register offsets
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;    // Out
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;    // In
   localparam logic [6:0] REG_TEST      = 7'd8;    // Out
   localparam logic [6:0] REG_XFER_RATE = 7'd14;   // Out

   localparam logic [WB_DW-1:0] MISC_DEFAULT = 16'hBEEF;

   // Bumped when the register map changes in an incompatible way
   localparam logic [SET_DW-1:0] COMPAT_NUM = {16'd8, 16'd0};   // Major, minor

   // Slave numbers in adr[10:7]
   localparam logic [3:0] SLV_MISC     = 4'd0;
   localparam logic [3:0] SLV_READBACK = 4'd7;

   //////////////////////////////
   // Bus types
   typedef struct packed {
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
      logic [WB_SW-1:0] sel;
      logic             we;
      logic             cyc;
      logic             stb;
   } wb_req_t;

   typedef struct packed {
      logic [WB_DW-1:0] dat;
      logic             ack;
   } wb_rsp_t;

   typedef struct packed {
      logic              stb;    // Single cycle, no back-pressure
      logic [SET_AW-1:0] addr;
      logic [SET_DW-1:0] data;
   } set_bus_t;

   typedef union packed {
      logic [SET_DW-1:0] w;
      struct packed {
         logic [WB_DW-1:0] hi;
         logic [WB_DW-1:0] lo;
      } h;
   } word32_u;

endpackage

`default_nettype wire

//--- design/wb_intercon.sv
// Single-master Wishbone intercon
// Decodes adr[10:7] to the misc, readback or settings slave,
// forwards stb to the selected slave only and muxes the response back

`default_nettype none
`timescale 1ns/1ps

module wb_intercon
  (input  logic             wb_clk,
   input  logic             core_rst,
   input  u1e_pkg::wb_req_t m_req_i,
   output u1e_pkg::wb_rsp_t m_rsp_o,
   output u1e_pkg::wb_req_t misc_req_o,
   input  u1e_pkg::wb_rsp_t misc_rsp_i,
   output u1e_pkg::wb_req_t rb_req_o,
   input  u1e_pkg::wb_rsp_t rb_rsp_i,
   output u1e_pkg::wb_req_t set_req_o,
   input  u1e_pkg::wb_rsp_t set_rsp_i);

   import u1e_pkg::*;

   logic [3:0] slv;
   logic       sel_misc, sel_rb, sel_set;
   logic       done;                        // Access already acked, stb still up

   assign slv      = m_req_i.adr[WB_AW-1 -: 4];
   assign sel_set  = slv[3];                // Upper half of the map
   assign sel_misc = (slv == SLV_MISC);
   assign sel_rb   = (slv == SLV_READBACK);

   always_comb
   begin
      misc_req_o     = m_req_i;
      rb_req_o       = m_req_i;
      set_req_o      = m_req_i;
      misc_req_o.stb = m_req_i.stb & sel_misc & ~done;
      rb_req_o.stb   = m_req_i.stb & sel_rb & ~done;
      set_req_o.stb  = m_req_i.stb & sel_set & ~done;
   end

   // Unmapped slaves never answer
   always_comb
   begin
      m_rsp_o = '0;
      if (sel_set)
         m_rsp_o = set_rsp_i;
      else if (sel_misc)
         m_rsp_o = misc_rsp_i;
      else if (sel_rb)
         m_rsp_o = rb_rsp_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (core_rst)
         done <= 1'b0;
      else if (!m_req_i.stb)
         done <= 1'b0;                      // Master has closed the access
      else if (m_rsp_o.ack)
         done <= 1'b1;
   end

endmodule

`default_nettype wire

//--- design/misc_regs.sv
// Misc register slave
// Clock-generator control and status, a test word and the transfer-rate word
// Single-cycle ack, unlisted offsets read back a fixed pattern

`default_nettype none
`timescale 1ns/1ps

module misc_regs
  (input  logic             wb_clk,
   input  logic             core_rst,
   input  u1e_pkg::wb_req_t req_i,
   output u1e_pkg::wb_rsp_t rsp_o,
   input  logic [2:0]       cgen_st_i,
   output logic             cgen_sync_b_o,
   output logic             cgen_ref_sel_o,
   output logic [7:0]       test_rate_o,
   output logic [3:0]       test_ctrl_o);

   import u1e_pkg::*;

   logic [WB_DW-1:0] reg_cgen_ctrl;
   logic [WB_DW-1:0] reg_test;
   logic [WB_DW-1:0] xfer_rate;
   logic [WB_DW-1:0] rd_dat;
   logic             wr_en;

   assign wr_en = req_i.cyc & req_i.stb & req_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (core_rst)
      begin
         reg_cgen_ctrl <= 16'd3;            // Sync deasserted, ref select high
         reg_test      <= '0;
         xfer_rate     <= '0;
      end
      else if (wr_en)
      begin
         case (req_i.adr[6:0])
            REG_CGEN_CTRL : reg_cgen_ctrl <= req_i.dat;
            REG_TEST      : reg_test      <= req_i.dat;
            REG_XFER_RATE : xfer_rate     <= req_i.dat;
            default       : ;
         endcase
      end
   end

   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];
   assign test_ctrl_o    = xfer_rate[11:8];
   assign test_rate_o    = xfer_rate[7:0];

   always_comb
   begin
      case (req_i.adr[6:0])
         REG_CGEN_CTRL : rd_dat = reg_cgen_ctrl;
         REG_CGEN_ST   : rd_dat = {13'd0, cgen_st_i};   // Status, ld, refmon
         REG_TEST      : rd_dat = reg_test;
         REG_XFER_RATE : rd_dat = xfer_rate;
         default       : rd_dat = MISC_DEFAULT;
      endcase
   end

   assign rsp_o.dat = rd_dat;
   assign rsp_o.ack = req_i.cyc & req_i.stb & ~core_rst;   // Same-cycle ack outside reset

endmodule

`default_nettype wire

//--- settings/settings_bus_16le.sv
// Wishbone to settings bus bridge, little endian
// Low half-word is held until the high half arrives,
// then one settings strobe carries the joined 32-bit word

`default_nettype none
`timescale 1ns/1ps

module settings_bus_16le
  (input  logic              wb_clk,
   input  logic              core_rst,
   input  u1e_pkg::wb_req_t  req_i,
   output u1e_pkg::wb_rsp_t  rsp_o,
   output u1e_pkg::set_bus_t set_o);

   import u1e_pkg::*;

   word32_u           word_q;               // Joined settings word
   logic [SET_AW-1:0] addr_q;
   logic              ack;
   logic              new_acc;              // First cycle of an access
   logic              lo_wr, hi_wr;
   logic              pend;                 // High half written, strobe next
   logic              stb_q;

   assign new_acc = req_i.cyc & req_i.stb & ~ack;
   assign lo_wr   = new_acc & req_i.we & ~req_i.adr[1];
   assign hi_wr   = new_acc & req_i.we & req_i.adr[1];

   always_ff @(posedge wb_clk)
   begin
      if (core_rst)
      begin
         ack   <= 1'b0;
         pend  <= 1'b0;
         stb_q <= 1'b0;
      end
      else
      begin
         ack   <= new_acc;
         pend  <= hi_wr;
         stb_q <= pend;                     // Cycle after the ack
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (lo_wr)
         word_q.h.lo <= req_i.dat;
      if (hi_wr)
      begin
         word_q.h.hi <= req_i.dat;
         addr_q      <= req_i.adr[9:2];     // 32-bit register index
      end
   end

   assign rsp_o.dat  = '0;                  // Write only
   assign rsp_o.ack  = ack;
   assign set_o.stb  = stb_q;
   assign set_o.addr = addr_q;
   assign set_o.data = word_q.w;

endmodule

`default_nettype wire

//--- settings/sys_settings.sv
// System settings
// Global-reset setting feeding the core reset synchronizer,
// and a 32-bit test setting that survives reset

`default_nettype none
`timescale 1ns/1ps

module sys_settings
  (input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  u1e_pkg::set_bus_t          set_i,
   output logic                       core_rst_o,
   output logic [u1e_pkg::SET_DW-1:0] reg_test32_o);

   import u1e_pkg::*;

   logic       glob_rst_p;                  // One-cycle pulse from the setting
   logic [1:0] rst_sync;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         glob_rst_p <= 1'b0;
      else
         glob_rst_p <= set_i.stb & (set_i.addr == SR_GLOBAL_RESET);
   end

   //////////////////////////////
   // Reset synchronizer
   // Core reset is held two cycles past the end of its source
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst | glob_rst_p)
         rst_sync <= 2'b11;
      else
         rst_sync <= {rst_sync[0], 1'b0};
   end

   assign core_rst_o = rst_sync[1];

   // Kept through any reset so software can tell the FPGA is already loaded
   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && (set_i.addr == SR_REG_TEST32))
         reg_test32_o <= set_i.data;
   end

endmodule

`default_nettype wire

//--- design/vita_time.sv
// VITA time counter
// 64-bit seconds/ticks time, loaded over the settings bus,
// with the time captured at each synchronized PPS rising edge

`default_nettype none
`timescale 1ns/1ps

module vita_time
  #(parameter int unsigned TICKS_PER_SEC = 64000000)
  (input  logic              wb_clk,
   input  logic              core_rst,
   input  u1e_pkg::set_bus_t set_i,
   input  logic              pps_i,
   output logic [63:0]       vita_time_o,
   output logic [63:0]       vita_time_pps_o);

   import u1e_pkg::*;

   localparam logic [31:0]       LAST_TICK = 32'(TICKS_PER_SEC - 1);
   localparam logic [SET_AW-1:0] SR_TICKS  = SR_TIME64 + 8'd1;

   logic [31:0] secs;
   logic [31:0] ticks;
   logic [31:0] pend_secs;                  // Waits for the ticks write
   logic        wr_secs, wr_ticks;
   logic [2:0]  pps_q;                      // Two sync flops plus one of history
   logic        pps_rise;

   assign wr_secs  = set_i.stb & (set_i.addr == SR_TIME64);
   assign wr_ticks = set_i.stb & (set_i.addr == SR_TICKS);

   always_ff @(posedge wb_clk)
   begin
      if (wr_secs)
         pend_secs <= set_i.data;
   end

   //////////////////////////////
   // Seconds and ticks
   always_ff @(posedge wb_clk)
   begin
      if (core_rst)
      begin
         secs  <= '0;
         ticks <= '0;
      end
      else if (wr_ticks)
      begin
         secs  <= pend_secs;                // Both halves land together
         ticks <= set_i.data;
      end
      else if (ticks == LAST_TICK)
      begin
         ticks <= '0;
         secs  <= secs + 32'd1;
      end
      else
         ticks <= ticks + 32'd1;
   end

   assign vita_time_o = {secs, ticks};

   // PPS capture
   always_ff @(posedge wb_clk)
   begin
      if (core_rst)
         pps_q <= '0;
      else
         pps_q <= {pps_q[1:0], pps_i};
   end

   assign pps_rise = pps_q[1] & ~pps_q[2];

   always_ff @(posedge wb_clk)
   begin
      if (core_rst)
         vita_time_pps_o <= '0;
      else if (pps_rise)
         vita_time_pps_o <= {secs, ticks};
   end

endmodule

`default_nettype wire

//--- design/readback_mux_16le.sv
// Readback mux slave
// Eight 32-bit status words read as 16-bit halves,
// word index from adr[4:2], high half when adr[1] is set

`default_nettype none
`timescale 1ns/1ps

module readback_mux_16le
  (input  logic                   wb_clk,
   input  logic                   core_rst,
   input  u1e_pkg::wb_req_t       req_i,
   output u1e_pkg::wb_rsp_t       rsp_o,
   input  u1e_pkg::word32_u [7:0] words_i);

   import u1e_pkg::*;

   word32_u          sel_word;
   logic [WB_DW-1:0] rd_dat;
   logic             ack;
   logic             new_acc;

   assign sel_word = words_i[req_i.adr[4:2]];
   assign new_acc  = req_i.cyc & req_i.stb & ~ack;   // One ack per access

   always_ff @(posedge wb_clk)
   begin
      if (core_rst)
         ack <= 1'b0;
      else
         ack <= new_acc;
   end

   always_ff @(posedge wb_clk)
   begin
      if (new_acc)
         rd_dat <= req_i.adr[1] ? sel_word.h.hi : sel_word.h.lo;
   end

   assign rsp_o.dat = rd_dat;
   assign rsp_o.ack = ack;

endmodule

`default_nettype wire

//--- design/u1e_ctrl_core.sv
// Radio core control plane, top level
// Wishbone intercon with misc, readback and settings slaves,
// system settings with the core reset, and the VITA time counter

`default_nettype none
`timescale 1ns/1ps

module u1e_ctrl_core
  #(parameter int unsigned TICKS_PER_SEC = 64000000)
  (input  logic             wb_clk,
   input  logic             wb_rst,
   input  u1e_pkg::wb_req_t wb_req_i,
   output u1e_pkg::wb_rsp_t wb_rsp_o,
   input  logic [2:0]       cgen_st_i,
   input  logic             pps_i,
   output logic             cgen_sync_b_o,
   output logic             cgen_ref_sel_o,
   output logic [7:0]       test_rate_o,
   output logic [3:0]       test_ctrl_o);

   import u1e_pkg::*;

   logic              core_rst;
   wb_req_t           misc_req, rb_req, set_req;
   wb_rsp_t           misc_rsp, rb_rsp, set_rsp;
   set_bus_t          set_bus;
   logic [SET_DW-1:0] reg_test32;
   logic [63:0]       vita_time, vita_time_pps;
   word32_u [7:0]     rb_words;

   sys_settings i_sys_settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus),
      .core_rst_o(core_rst), .reg_test32_o(reg_test32));

   //////////////////////////////
   // Wishbone side
   wb_intercon i_intercon
     (.wb_clk(wb_clk), .core_rst(core_rst),
      .m_req_i(wb_req_i), .m_rsp_o(wb_rsp_o),
      .misc_req_o(misc_req), .misc_rsp_i(misc_rsp),
      .rb_req_o(rb_req), .rb_rsp_i(rb_rsp),
      .set_req_o(set_req), .set_rsp_i(set_rsp));

   misc_regs i_misc_regs
     (.wb_clk(wb_clk), .core_rst(core_rst), .req_i(misc_req), .rsp_o(misc_rsp),
      .cgen_st_i(cgen_st_i), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o),
      .test_rate_o(test_rate_o), .test_ctrl_o(test_ctrl_o));

   settings_bus_16le i_settings_bus
     (.wb_clk(wb_clk), .core_rst(core_rst), .req_i(set_req), .rsp_o(set_rsp),
      .set_o(set_bus));

   //////////////////////////////
   // Timing and readback
   vita_time #(.TICKS_PER_SEC(TICKS_PER_SEC)) i_vita_time
     (.wb_clk(wb_clk), .core_rst(core_rst), .set_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   assign rb_words[0].w = vita_time[63:32];        // Seconds
   assign rb_words[1].w = vita_time[31:0];         // Ticks
   assign rb_words[2].w = vita_time_pps[63:32];
   assign rb_words[3].w = vita_time_pps[31:0];
   assign rb_words[4].w = reg_test32;
   assign rb_words[5].w = COMPAT_NUM;
   assign rb_words[6].w = '0;
   assign rb_words[7].w = '0;

   readback_mux_16le i_readback
     (.wb_clk(wb_clk), .core_rst(core_rst), .req_i(rb_req), .rsp_o(rb_rsp),
      .words_i(rb_words));

endmodule

`default_nettype wire

//--- tb/u1e_ctrl_asserts.sv
// Protocol assertions for the radio control core
// Bound into the top level, watches the Wishbone handshake,
// the settings strobe and the core reset

`default_nettype none
`timescale 1ns/1ps

module u1e_ctrl_asserts
  (input logic              wb_clk,
   input logic              core_rst_i,
   input u1e_pkg::wb_req_t  req_i,
   input u1e_pkg::wb_rsp_t  rsp_i,
   input u1e_pkg::set_bus_t set_bus_i);

   int fail_cnt = 0;                            // Read by the testbench at the end

   //////////////////////////////
   // Wishbone side
   ack_in_access : assert property (@(posedge wb_clk)
      rsp_i.ack |-> (req_i.cyc && req_i.stb))
   else
   begin
      fail_cnt++;
      $error("ack outside a cyc/stb access");
   end

   no_ack_in_reset : assert property (@(posedge wb_clk)
      core_rst_i |-> !rsp_i.ack)
   else
   begin
      fail_cnt++;
      $error("ack while the core reset is high");
   end

   // Settings strobe is a single-cycle pulse
   set_stb_single : assert property (@(posedge wb_clk)
      set_bus_i.stb |=> !set_bus_i.stb)
   else
   begin
      fail_cnt++;
      $error("settings strobe longer than one cycle");
   end

endmodule

bind u1e_ctrl_core u1e_ctrl_asserts i_asserts
  (.wb_clk(wb_clk), .core_rst_i(core_rst), .req_i(wb_req_i), .rsp_i(wb_rsp_o),
   .set_bus_i(set_bus));

`default_nettype wire

//--- tb/u1e_ctrl_tb.sv
// Radio control core testbench
// Drives the Wishbone master side from a stimulus table,
// checks register, settings, readback, time and reset behavior

`default_nettype none
`timescale 1ns/1ps

module u1e_ctrl_tb;

   import u1e_pkg::*;

   localparam int unsigned SEED    = 32'hac90_2a7e;
   localparam int          ACK_LIM = 16;        // Cycles a slave gets to answer

   localparam logic [2:0] OP_WR    = 3'd0;      // Wishbone write
   localparam logic [2:0] OP_RD    = 3'd1;      // Read, compare equal
   localparam logic [2:0] OP_RDLT  = 3'd2;      // Read, compare below
   localparam logic [2:0] OP_SET   = 3'd3;      // 32-bit settings write
   localparam logic [2:0] OP_IDLE  = 3'd4;
   localparam logic [2:0] OP_PPS   = 3'd5;
   localparam logic [2:0] OP_NOACK = 3'd6;      // Unmapped access
   localparam logic [2:0] OP_PINS  = 3'd7;      // Output pin check

   typedef struct packed {
      logic [2:0]  op;
      logic [10:0] adr;
      logic [31:0] data;
      logic [15:0] exp;
   } row_t;

   logic        wb_clk;
   logic        wb_rst;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic [2:0]  cgen_st;
   logic        pps;
   logic        cgen_sync_b, cgen_ref_sel;
   logic [7:0]  test_rate;
   logic [3:0]  test_ctrl;

   row_t        table_q[$];
   int unsigned seed_val;
   int          val_errs   = 0;
   int          proto_errs = 0;
   int          cycles     = 0;
   int          cyc_lim    = 3000;

   u1e_ctrl_core #(.TICKS_PER_SEC(1000)) i_dut
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .cgen_st_i(cgen_st), .pps_i(pps), .cgen_sync_b_o(cgen_sync_b),
      .cgen_ref_sel_o(cgen_ref_sel), .test_rate_o(test_rate), .test_ctrl_o(test_ctrl));

   initial
   begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
   begin
      cycles++;
      if (cycles >= cyc_lim)
      begin
         $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   //////////////////////////////
   // Address helpers from the bus map
   function automatic logic [10:0] misc_adr(input logic [6:0] off);
      return {SLV_MISC, off};
   endfunction

   function automatic logic [10:0] rb_adr(input logic [2:0] idx, input logic hi);
      return {SLV_READBACK, 2'b00, idx, hi, 1'b0};
   endfunction

   function automatic logic [10:0] set_adr(input logic [7:0] addr, input logic hi);
      return {1'b1, addr, hi, 1'b0};  // Settings half of the map
   endfunction

   //////////////////////////////
   // Bus tasks
   task automatic wb_access(input logic we, input logic [10:0] adr, input logic [15:0] wdat,
                            output logic [15:0] rdat, output bit acked);
      int n;
      begin
         n     = 0;
         acked = 1'b0;
         rdat  = '0;
         @(posedge wb_clk);
         #1;
         wb_req.adr = adr;
         wb_req.dat = wdat;
         wb_req.sel = 2'b11;
         wb_req.we  = we;
         wb_req.cyc = 1'b1;
         wb_req.stb = 1'b1;
         while (!acked && n < ACK_LIM)
         begin
            @(negedge wb_clk);                 // Mid-cycle, response is settled
            if (wb_rsp.ack)
            begin
               acked = 1'b1;
               rdat  = wb_rsp.dat;
            end
            n++;
         end
         @(posedge wb_clk);                    // Edge that ends the access
         #1;
         wb_req.cyc = 1'b0;
         wb_req.stb = 1'b0;
         wb_req.we  = 1'b0;
      end
   endtask

   task automatic wb_write(input logic [10:0] adr, input logic [15:0] dat);
      logic [15:0] unused;
      bit          acked;
      begin
         wb_access(1'b1, adr, dat, unused, acked);
         assert (acked)
         else
         begin
            $display("Write to address %h got no ack within %0d cycles", adr, ACK_LIM);
            proto_errs++;
         end
      end
   endtask

   task automatic wb_read(input logic [10:0] adr, output logic [15:0] dat);
      bit acked;
      begin
         wb_access(1'b0, adr, 16'h0000, dat, acked);
         assert (acked)
         else
         begin
            $display("Read from address %h got no ack within %0d cycles", adr, ACK_LIM);
            proto_errs++;
         end
      end
   endtask

   // Low half first, the high half fires the settings strobe
   task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
      begin
         wb_write(set_adr(addr, 1'b0), data[15:0]);
         wb_write(set_adr(addr, 1'b1), data[31:16]);
      end
   endtask

   task automatic pps_pulse();
      begin
         @(posedge wb_clk);
         #1 pps = 1'b1;
         repeat (4) @(posedge wb_clk);
         #1 pps = 1'b0;
         repeat (4) @(posedge wb_clk);         // Two sync flops plus the edge detect
      end
   endtask

   task automatic no_ack_check(input logic [10:0] adr);
      logic [15:0] unused;
      bit          acked;
      begin
         wb_access(1'b0, adr, 16'h0000, unused, acked);
         assert (!acked)
         else
         begin
            $display("Unmapped address %h was acknowledged, no slave should answer", adr);
            proto_errs++;
         end
      end
   endtask

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      begin
         assert (got === exp)
         else
         begin
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            val_errs++;
         end
      end
   endtask

   // Read issued while wb_rst is still high and answered once the core reset ends
   task automatic read_across_reset(input logic [10:0] adr, input logic [15:0] exp);
      logic [15:0] rd;
      begin
         fork
            begin
               repeat (4) @(posedge wb_clk);
               #1 wb_rst = 1'b0;
            end
            wb_read(adr, rd);
         join
         check_value($sformatf("wb_rsp_o.dat (adr %h)", adr), rd, exp);
      end
   endtask

   //////////////////////////////
   // Stimulus table
   task automatic add_row(input logic [2:0] op, input logic [10:0] adr,
                          input logic [31:0] data, input logic [15:0] exp);
      row_t r;
      begin
         r.op   = op;
         r.adr  = adr;
         r.data = data;
         r.exp  = exp;
         table_q.push_back(r);
      end
   endtask

   task automatic build_table();
      logic [15:0] rt, rx;
      logic [31:0] r32;
      begin
         rt  = 16'($urandom);
         rx  = 16'($urandom);
         r32 = $urandom;
         // After reset
         add_row(OP_RD, misc_adr(REG_CGEN_CTRL), '0, 16'd3);
         add_row(OP_PINS, '0, '0, {2'b00, 2'b11, 12'h000});
         add_row(OP_RD, misc_adr(7'd20), '0, 16'hBEEF);
         // Misc registers
         add_row(OP_WR, misc_adr(REG_TEST), {16'h0, rt}, '0);
         add_row(OP_RD, misc_adr(REG_TEST), '0, rt);
         add_row(OP_WR, misc_adr(REG_XFER_RATE), {16'h0, rx}, '0);
         add_row(OP_RD, misc_adr(REG_XFER_RATE), '0, rx);
         add_row(OP_PINS, '0, '0, {2'b00, 2'b11, rx[11:8], rx[7:0]});
         add_row(OP_RD, misc_adr(REG_CGEN_ST), '0, {13'd0, cgen_st});
         // Settings write and readback words
         add_row(OP_SET, {3'b000, SR_REG_TEST32}, r32, '0);
         add_row(OP_RD, rb_adr(3'd4, 1'b0), '0, r32[15:0]);
         add_row(OP_RD, rb_adr(3'd4, 1'b1), '0, r32[31:16]);
         add_row(OP_RD, rb_adr(3'd5, 1'b0), '0, 16'h0000);   // Minor 0
         add_row(OP_RD, rb_adr(3'd5, 1'b1), '0, 16'd8);      // Major 8
         // Time load and PPS capture, all well inside one second
         add_row(OP_SET, {3'b000, SR_TIME64}, 32'd5, '0);
         add_row(OP_SET, {3'b000, SR_TIME64 + 8'd1}, 32'd0, '0);
         add_row(OP_RD, rb_adr(3'd0, 1'b0), '0, 16'd5);
         add_row(OP_RD, rb_adr(3'd0, 1'b1), '0, 16'd0);
         add_row(OP_PPS, '0, '0, '0);
         add_row(OP_RD, rb_adr(3'd2, 1'b0), '0, 16'd5);
         add_row(OP_RD, rb_adr(3'd3, 1'b1), '0, 16'd0);
         add_row(OP_RDLT, rb_adr(3'd3, 1'b0), '0, 16'd1000);
         // Global reset clears misc but not test32
         add_row(OP_SET, {3'b000, SR_GLOBAL_RESET}, 32'd1, '0);
         add_row(OP_IDLE, '0, 32'd8, '0);
         add_row(OP_RD, misc_adr(REG_TEST), '0, 16'd0);
         add_row(OP_RD, rb_adr(3'd4, 1'b0), '0, r32[15:0]);
         add_row(OP_RD, rb_adr(3'd4, 1'b1), '0, r32[31:16]);
         add_row(OP_NOACK, {4'd1, 7'd8}, '0, '0);            // Slave 1 is unmapped
      end
   endtask

   initial
   begin
      row_t        r;
      logic [15:0] rd;
      wb_req   = '0;
      wb_rst   = 1'b1;
      pps      = 1'b0;
      cgen_st  = '0;
      seed_val = $urandom(SEED);
      cgen_st  = 3'($urandom);
      build_table();
      cyc_lim  = 20 * table_q.size() + 3000;
      repeat (4) @(posedge wb_clk);
      read_across_reset(misc_adr(REG_CGEN_CTRL), 16'd3);
      foreach (table_q[i])
      begin
         r = table_q[i];
         case (r.op)
            OP_WR    : wb_write(r.adr, r.data[15:0]);
            OP_SET   : set_write(r.adr[7:0], r.data);
            OP_IDLE  : repeat (r.data) @(posedge wb_clk);
            OP_PPS   : pps_pulse();
            OP_NOACK : no_ack_check(r.adr);
            OP_RD    :
            begin
               wb_read(r.adr, rd);
               check_value($sformatf("wb_rsp_o.dat (adr %h)", r.adr), rd, r.exp);
            end
            OP_RDLT  :
            begin
               wb_read(r.adr, rd);
               assert (rd < r.exp)
               else
               begin
                  $display("error at %0t ns: wb_rsp_o.dat (adr %h) got %h expected below %h",
                           $time, r.adr, rd, r.exp);
                  val_errs++;
               end
            end
            default  :
            begin
               @(negedge wb_clk);
               check_value("{cgen_sync_b_o, cgen_ref_sel_o, test_ctrl_o, test_rate_o}",
                           {2'b00, cgen_sync_b, cgen_ref_sel, test_ctrl, test_rate}, r.exp);
            end
         endcase
      end
      repeat (4) @(posedge wb_clk);
      $display("Summary: %0d value errors, %0d bus errors, %0d assertion failures",
               val_errs, proto_errs, i_dut.i_asserts.fail_cnt);
      if (val_errs + proto_errs + i_dut.i_asserts.fail_cnt == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
common/u1e_pkg.sv
design/wb_intercon.sv
design/misc_regs.sv
settings/settings_bus_16le.sv
settings/sys_settings.sv
design/vita_time.sv
design/readback_mux_16le.sv
design/u1e_ctrl_core.sv
tb/u1e_ctrl_asserts.sv
tb/u1e_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the control core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=u1e_ctrl_tb
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module "$TOP" -o sim_bin \
   > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_bin +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Checks failed" "$LOG"; then
   exit 1
fi
exit 0
